// File: design/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      valid,
    input  wire                      op,
    input  wire dcache_pkg::tag_t     tag,
    input  wire dcache_pkg::index_t   index,
    input  wire dcache_pkg::offset_t  offset,
    input  wire dcache_pkg::strb_t    wstrb,
    input  wire dcache_pkg::word_t    wdata,
    input  wire                      hit,
    input  wire dcache_pkg::way_sel_t hit_way,
    input  wire dcache_pkg::way_sel_t victim_way,
    input  wire                      victim_dirty,
    input  wire dcache_pkg::tag_t     victim_tag,
    input  wire dcache_pkg::line_t    victim_line,
    input  wire                      rd_rdy,
    input  wire                      ret_valid,
    input  wire                      ret_last,
    input  wire                      wr_rdy,
    output dcache_pkg::index_t       req_index,
    output dcache_pkg::tag_t         req_tag,
    output dcache_pkg::offset_t      req_offset,
    output dcache_pkg::strb_t        req_wstrb,
    output dcache_pkg::word_t        req_wdata,
    output dcache_pkg::way_sel_t     fill_en,
    output dcache_pkg::way_sel_t     store_en,
    output logic                     word_en,
    output logic                     addr_ok,
    output logic                     data_ok,
    output logic                     busy,
    output logic                     rd_req,
    output dcache_pkg::addr_t        rd_addr,
    output logic                     wr_req,
    output dcache_pkg::addr_t        wr_addr,
    output dcache_pkg::line_t        wr_data
);
    import dcache_pkg::*;

    ctrl_state_t state;
    logic        req_op;
    logic        refill_done;

    assign refill_done = (state == main_refill) && ret_valid && ret_last;

    // request buffer, loaded when a request is taken in idle
    always_ff @(posedge clk) begin
        if (state == main_idle && valid) begin
            req_tag    <= tag;
            req_index  <= index;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state  <= main_idle;
            req_op <= 1'b0;
        end else begin
            case (state)
                main_idle: begin
                    if (valid) begin
                        state  <= main_lookup;
                        req_op <= op;
                    end
                end
                main_lookup: begin
                    if (hit) begin
                        state <= req_op ? main_write : main_idle;
                    end else if (victim_dirty) begin
                        state <= main_write_back;
                    end else begin
                        state <= main_replace;
                    end
                end
                main_write_back: begin
                    if (wr_rdy) begin
                        state <= main_replace;
                    end
                end
                main_replace: begin
                    if (rd_rdy) begin
                        state <= main_refill;
                    end
                end
                main_refill: begin
                    if (refill_done) begin
                        state <= main_retry;
                    end
                end
                // the line was filled on ret_last, so this always hits
                main_retry:  state <= req_op ? main_write : main_idle;
                main_write:  state <= main_idle;
                default:     state <= main_idle;
            endcase
        end
    end

    assign busy    = (state != main_idle);
    assign addr_ok = (state == main_lookup);
    assign data_ok = (state == main_lookup || state == main_retry) && hit;

    // way updates
    assign word_en  = (state == main_refill) && ret_valid;
    assign fill_en  = refill_done ? victim_way : '0;
    assign store_en = (state == main_write) ? hit_way : '0;

    // line refill request, held until the bus takes it
    assign rd_req  = (state == main_replace);
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};

    // dirty victim goes out as one full line
    assign wr_req  = (state == main_write_back) && wr_rdy;
    assign wr_addr = {victim_tag, req_index, {OFFSET_W{1'b0}}};
    assign wr_data = victim_line;

endmodule

`default_nettype wire

// File: design/dcache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup (
    input  wire                      way0_valid,
    input  wire                      way0_dirty,
    input  wire dcache_pkg::tag_t     way0_tag,
    input  wire dcache_pkg::line_t    way0_line,
    input  wire                      way1_valid,
    input  wire                      way1_dirty,
    input  wire dcache_pkg::tag_t     way1_tag,
    input  wire dcache_pkg::line_t    way1_line,
    input  wire dcache_pkg::tag_t     req_tag,
    input  wire dcache_pkg::offset_t  req_offset,
    input  wire dcache_pkg::strb_t    req_wstrb,
    input  wire dcache_pkg::word_t    req_wdata,
    output logic                     hit,
    output dcache_pkg::way_sel_t     hit_way,
    output dcache_pkg::word_t        load_word,
    output dcache_pkg::line_t        merged_line,
    output dcache_pkg::way_sel_t     victim_way,
    output logic                     victim_dirty,
    output dcache_pkg::tag_t         victim_tag,
    output dcache_pkg::line_t        victim_line
);
    import dcache_pkg::*;

    logic [OFFSET_W-3:0] word_sel;
    line_t               hit_line;
    word_t               new_word;

    assign word_sel = req_offset[OFFSET_W-1:2];

    // tag compare on valid ways only
    assign hit_way[0] = way0_valid && (way0_tag == req_tag);
    assign hit_way[1] = way1_valid && (way1_tag == req_tag);
    assign hit        = |hit_way;

    assign hit_line  = hit_way[1] ? way1_line : way0_line;
    assign load_word = hit_line[word_sel*32 +: 32];

    // byte merge of the store data
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            new_word[b*8 +: 8] = req_wstrb[b] ? req_wdata[b*8 +: 8] : load_word[b*8 +: 8];
        end
        merged_line = hit_line;
        merged_line[word_sel*32 +: 32] = new_word;
    end

    // invalid way first, then a clean one, else way 0
    always_comb begin
        if (!way0_valid) begin
            victim_way = 2'b01;
        end else if (!way1_valid) begin
            victim_way = 2'b10;
        end else if (!way0_dirty) begin
            victim_way = 2'b01;
        end else if (!way1_dirty) begin
            victim_way = 2'b10;
        end else begin
            victim_way = 2'b01;
        end
    end

    assign victim_dirty = victim_way[1] ? (way1_valid && way1_dirty) : (way0_valid && way0_dirty);
    assign victim_tag   = victim_way[1] ? way1_tag : way0_tag;
    assign victim_line  = victim_way[1] ? way1_line : way0_line;

endmodule

`default_nettype wire

// File: design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // address split of a 32-bit byte address
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 4;

    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_WAYS       = 2;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [31:0]         word_t;
    typedef logic [3:0]          strb_t;

    // word 0 sits in the low bits
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;

    typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0] addr_t;

    // one-hot, bit 0 is way 0
    typedef logic [NUM_WAYS-1:0] way_sel_t;

    // one-hot controller states
    typedef enum logic [6:0] {
        main_idle       = 7'b0000001,
        main_lookup     = 7'b0000010,
        main_write_back = 7'b0000100,
        main_replace    = 7'b0001000,
        main_refill     = 7'b0010000,
        main_retry      = 7'b0100000,
        main_write      = 7'b1000000
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/dcache_refill_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_refill_buffer (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire                   word_en,
    input  wire dcache_pkg::word_t ret_data,
    output dcache_pkg::line_t     fill_line
);
    import dcache_pkg::*;

    // counts returned words, wraps after the last one
    logic [$clog2(WORDS_PER_LINE)-1:0] cnt_q;
    word_t buf_q [WORDS_PER_LINE-1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt_q <= '0;
        end else if (word_en) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // only the first three words are kept
    always_ff @(posedge clk) begin
        if (word_en) begin
            case (cnt_q)
                2'd0:    buf_q[0] <= ret_data;
                2'd1:    buf_q[1] <= ret_data;
                2'd2:    buf_q[2] <= ret_data;
                default: ;
            endcase
        end
    end

    // last word comes straight from the bus, so the fill lands on ret_last
    assign fill_line = {ret_data, buf_q[2], buf_q[1], buf_q[0]};

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      valid,
    input  wire                      op,
    input  wire dcache_pkg::tag_t     tag,
    input  wire dcache_pkg::index_t   index,
    input  wire dcache_pkg::offset_t  offset,
    input  wire dcache_pkg::strb_t    wstrb,
    input  wire dcache_pkg::word_t    wdata,
    output logic                     addr_ok,
    output logic                     data_ok,
    output dcache_pkg::word_t        rdata,
    output logic                     busy,
    output logic                     rd_req,
    output dcache_pkg::addr_t        rd_addr,
    input  wire                      rd_rdy,
    input  wire                      ret_valid,
    input  wire                      ret_last,
    input  wire dcache_pkg::word_t    ret_data,
    output logic                     wr_req,
    output dcache_pkg::addr_t        wr_addr,
    output dcache_pkg::line_t        wr_data,
    input  wire                      wr_rdy
);
    import dcache_pkg::*;

    index_t   req_index;
    tag_t     req_tag;
    offset_t  req_offset;
    strb_t    req_wstrb;
    word_t    req_wdata;
    logic     way0_valid, way0_dirty, way1_valid, way1_dirty;
    tag_t     way0_tag, way1_tag, victim_tag;
    line_t    way0_line, way1_line, merged_line, victim_line, fill_line;
    logic     hit, victim_dirty, word_en;
    way_sel_t hit_way, victim_way, fill_en, store_en;

    dcache_ctrl u_ctrl (.*);

    dcache_lookup u_lookup (.*, .load_word(rdata));

    dcache_refill_buffer u_refill_buffer (.*);

    dcache_way u_way0 (
        .clk(clk), .resetn(resetn), .index(req_index),
        .fill_en(fill_en[0]), .fill_tag(req_tag), .fill_line(fill_line),
        .store_en(store_en[0]), .store_line(merged_line),
        .rd_valid(way0_valid), .rd_dirty(way0_dirty), .rd_tag(way0_tag), .rd_line(way0_line)
    );

    dcache_way u_way1 (
        .clk(clk), .resetn(resetn), .index(req_index),
        .fill_en(fill_en[1]), .fill_tag(req_tag), .fill_line(fill_line),
        .store_en(store_en[1]), .store_line(merged_line),
        .rd_valid(way1_valid), .rd_dirty(way1_dirty), .rd_tag(way1_tag), .rd_line(way1_line)
    );

endmodule

`default_nettype wire

// File: design/dcache_way.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_way (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire dcache_pkg::index_t index,
    input  wire                   fill_en,
    input  wire dcache_pkg::tag_t  fill_tag,
    input  wire dcache_pkg::line_t fill_line,
    input  wire                   store_en,
    input  wire dcache_pkg::line_t store_line,
    output logic                  rd_valid,
    output logic                  rd_dirty,
    output dcache_pkg::tag_t      rd_tag,
    output dcache_pkg::line_t     rd_line
);
    import dcache_pkg::*;

    localparam int SETS = 1 << INDEX_W;

    // per-set status bits
    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;

    // tag and data arrays
    tag_t  tag_mem  [SETS];
    line_t line_mem [SETS];

    // a fill brings in a clean line, a store marks it dirty
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
        end else if (store_en) begin
            dirty_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[index]  <= fill_tag;
            line_mem[index] <= fill_line;
        end else if (store_en) begin
            line_mem[index] <= store_line;
        end
    end

    // combinational read at the buffered index
    assign rd_valid = valid_q[index];
    assign rd_dirty = dirty_q[index];
    assign rd_tag   = tag_mem[index];
    assign rd_line  = line_mem[index];

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module dcache_tb -o dcache_sim
./obj_dir/dcache_sim 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// File: tb.f
design/dcache_pkg.sv
design/dcache_way.sv
design/dcache_lookup.sv
design/dcache_refill_buffer.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv

// File: verification/dcache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
    input wire                          clk,
    input wire                          resetn,
    input wire dcache_pkg::ctrl_state_t state,
    input wire                          rd_req,
    input wire                          rd_rdy,
    input wire                          wr_req,
    input wire                          wr_rdy,
    input wire                          data_ok,
    input wire                          busy
);
    import dcache_pkg::*;

    // one bus request at a time
    a_single_request: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
        else $error("rd_req and wr_req high in the same cycle");

    // write-back pulse only with wr_rdy
    a_write_pulse: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |-> wr_rdy)
        else $error("wr_req without wr_rdy");

    // a finished write-back moves on to the line read
    a_write_then_read: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |=> (state == main_replace))
        else $error("write-back not followed by the replace state");

    // line request held until the bus takes it
    a_read_held: assert property (@(posedge clk) disable iff (!resetn)
        (rd_req && !rd_rdy) |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    a_data_busy: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> busy)
        else $error("data_ok while the controller is idle");

endmodule

bind dcache_ctrl dcache_assertions u_assertions (
    .clk(clk), .resetn(resetn), .state(state),
    .rd_req(rd_req), .rd_rdy(rd_rdy), .wr_req(wr_req), .wr_rdy(wr_rdy),
    .data_ok(data_ok), .busy(busy)
);

`default_nettype wire

// File: verification/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int NUM_REQ  = 600;
    localparam int MAX_WAIT = 400;

    logic    clk, resetn, valid, op;
    tag_t    tag;
    index_t  index;
    offset_t offset;
    strb_t   wstrb;
    word_t   wdata, rdata, ret_data;
    logic    addr_ok, data_ok, busy, rd_req, rd_rdy, ret_valid, ret_last;
    logic    wr_req, wr_rdy;
    addr_t   rd_addr, wr_addr;
    line_t   wr_data;

    logic [31:0] lfsr;
    int          value_errors;
    int          other_errors;
    logic        timed_out;

    // bus memory, words never written read back a fill pattern
    word_t mem [addr_t];

    // model of both ways for every set
    logic  m_valid [2][256];
    logic  m_dirty [2][256];
    tag_t  m_tag   [2][256];
    line_t m_line  [2][256];

    dcache_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t mem_read(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return (a * 32'h9e3779b1) ^ 32'h6b43a9f1;
    endfunction

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("%0t: %s", $time, msg);
    endtask

    // CPU inputs while busy, the DUT must ignore them
    task automatic drive_junk_request();
        valid  = 1'(rand_bits(1));
        op     = 1'(rand_bits(1));
        tag    = tag_t'(rand_bits(20));
        index  = index_t'(rand_bits(8));
        offset = offset_t'(rand_bits(4));
        wstrb  = strb_t'(rand_bits(4));
        wdata  = rand_bits(32);
    endtask

    // called on a falling edge with busy low
    task automatic run_request(input logic r_op, input tag_t r_tag, input index_t r_idx,
                               input offset_t r_off, input strb_t r_strb, input word_t r_data);
        logic  hit_m;
        logic  way;
        logic  exp_wb;
        logic  rd_seen = 1'b0;
        logic  refilling = 1'b0;
        addr_t line_addr;
        addr_t exp_wb_addr;
        line_t exp_wb_line;
        line_t line;
        word_t exp_rdata;
        int    addr_oks = 0, data_oks = 0, wbs = 0, rds = 0, words = 0, cycles = 0;

        line_addr   = {r_tag, r_idx, 4'h0};
        hit_m       = 1'b1;
        exp_wb      = 1'b0;
        exp_wb_addr = '0;
        exp_wb_line = '0;
        if (m_valid[1][r_idx] && m_tag[1][r_idx] == r_tag) begin
            way = 1'b1;
        end else if (m_valid[0][r_idx] && m_tag[0][r_idx] == r_tag) begin
            way = 1'b0;
        end else begin
            hit_m = 1'b0;
            // way 1 only when way 0 is valid and way 1 is invalid or the only clean one
            way = m_valid[0][r_idx] &&
                  (!m_valid[1][r_idx] || (m_dirty[0][r_idx] && !m_dirty[1][r_idx]));
            exp_wb      = m_valid[way][r_idx] && m_dirty[way][r_idx];
            exp_wb_addr = {m_tag[way][r_idx], r_idx, 4'h0};
            exp_wb_line = m_line[way][r_idx];
            for (int w = 0; w < 4; w++) begin
                line[w*32 +: 32] = mem_read(line_addr + w*4);
            end
            m_valid[way][r_idx] = 1'b1;
            m_dirty[way][r_idx] = 1'b0;
            m_tag[way][r_idx]   = r_tag;
            m_line[way][r_idx]  = line;
        end
        line      = m_line[way][r_idx];
        exp_rdata = line[r_off[3:2]*32 +: 32];
        if (r_op) begin
            for (int b = 0; b < 4; b++) begin
                if (r_strb[b]) begin
                    line[r_off[3:2]*32 + b*8 +: 8] = r_data[b*8 +: 8];
                end
            end
            m_line[way][r_idx]  = line;
            m_dirty[way][r_idx] = 1'b1;
        end

        valid     = 1'b1;
        op        = r_op;
        tag       = r_tag;
        index     = r_idx;
        offset    = r_off;
        wstrb     = r_strb;
        wdata     = r_data;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            if (busy) begin
                drive_junk_request();
                rd_rdy    = 1'(rand_bits(1));
                wr_rdy    = 1'(rand_bits(1));
                ret_valid = refilling && (rand_bits(2) != 0);
                ret_last  = ret_valid && (words == 3);
                ret_data  = mem_read(line_addr + words*4);
                #1;
                if (addr_ok) begin
                    addr_oks++;
                end
                if (wr_req) begin
                    wbs++;
                    compare_addr("wr_addr", wr_addr, exp_wb_addr);
                    compare_line("wr_data", wr_data, exp_wb_line);
                    for (int w = 0; w < 4; w++) begin
                        mem[wr_addr + w*4] = wr_data[w*32 +: 32];
                    end
                end
                if (rd_req) begin
                    rd_seen = 1'b1;
                end
                if (rd_req && rd_rdy) begin
                    rds++;
                    compare_addr("rd_addr", rd_addr, line_addr);
                    if (exp_wb && wbs == 0) begin
                        report_failure("line read requested before the dirty victim went out");
                    end
                    refilling = 1'b1;
                    words     = 0;
                end
                if (ret_valid) begin
                    words++;
                    refilling = (words < 4);
                end
                if (data_ok) begin
                    data_oks++;
                    if (!r_op) begin
                        compare_word("rdata", rdata, exp_rdata);
                    end
                end
            end
        end while (busy && cycles < MAX_WAIT);

        if (busy) begin
            timed_out = 1'b1;
            report_failure($sformatf("request to %h did not finish in %0d cycles",
                                     line_addr, MAX_WAIT));
        end else begin
            if (addr_oks != 1 || data_oks != 1) begin
                report_failure($sformatf("request gave %0d addr_ok and %0d data_ok pulses",
                                         addr_oks, data_oks));
            end
            if (hit_m && (rd_seen || wbs != 0)) begin
                report_failure("bus request seen on a request the model counts as a hit");
            end
            if (!hit_m && (rds != 1 || wbs != (exp_wb ? 1 : 0))) begin
                report_failure($sformatf("miss gave %0d line reads and %0d write-backs",
                                         rds, wbs));
            end
        end
    endtask

    initial begin
        logic    r_op;
        tag_t    r_tag;
        index_t  r_idx;
        offset_t r_off;
        strb_t   r_strb;
        word_t   r_data;

        lfsr         = 32'h792a38d0;
        value_errors = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        resetn       = 1'b0;
        valid        = 1'b0;
        op           = 1'b0;
        tag          = '0;
        index        = '0;
        offset       = '0;
        wstrb        = '0;
        wdata        = '0;
        rd_rdy       = 1'b0;
        wr_rdy       = 1'b0;
        ret_valid    = 1'b0;
        ret_last     = 1'b0;
        ret_data     = '0;
        m_valid      = '{default: '0};
        m_dirty      = '{default: '0};

        repeat (2) @(negedge clk);
        resetn = 1'b1;
        #1;
        if (busy || addr_ok || data_ok || rd_req || wr_req) begin
            report_failure("cache outputs not idle after reset");
        end

        // four tags over four sets, so both ways fill and evict often
        @(negedge clk);
        for (int i = 0; i < NUM_REQ && !timed_out; i++) begin
            r_op   = 1'(rand_bits(1));
            r_tag  = {18'h2c51b, 2'(rand_bits(2))};
            r_idx  = {6'h1d, 2'(rand_bits(2))};
            r_off  = {2'(rand_bits(2)), 2'b00};
            r_strb = strb_t'(rand_bits(4));
            r_data = rand_bits(32);
            run_request(r_op, r_tag, r_idx, r_off, r_strb, r_data);
        end
        valid = 1'b0;

        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if (timed_out || value_errors != 0 || other_errors != 0) begin
            $display(">>> FAIL");
        end else begin
            $display(">>> PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire
